//--- rtl/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// buffer geometry
`define CH_ENTRIES   5
`define CH_BANKS     4

// request fields
`define CH_ADDR_MSB  31
`define CH_ADDR_LSB  4
`define CH_DATA_W    128
`define CH_OP_W      2

// addr[9:8] picks the bank
`define CH_BANK_LSB  8

`endif

//--- rtl/xbar_pkg.sv
`default_nettype none

`include "xbar_settings.svh"

package xbar_pkg;

  typedef logic [`CH_OP_W-1:0]                 op_t;
  typedef logic [`CH_ADDR_MSB:`CH_ADDR_LSB]    addr_t;  // line address, no offset bits
  typedef logic [`CH_DATA_W-1:0]               data_t;

  typedef struct packed {
    op_t   op;
    addr_t addr;
    data_t data;
  } ch_req_t;

  typedef logic [$clog2(`CH_ENTRIES)-1:0]      entry_id_t;
  typedef logic [`CH_ENTRIES-1:0]              entry_vec_t;
  typedef logic [$clog2(`CH_BANKS)-1:0]        bank_id_t;

  typedef ch_req_t ch_req_arr_t [`CH_ENTRIES];

  // ops that need the keep-order fifo
  localparam op_t       OP_ORDERED   = '0;
  localparam entry_id_t ENTRY_ID_MAX = entry_id_t'(`CH_ENTRIES - 1);

endpackage

`default_nettype wire

//--- rtl/xbar_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// ----------------------------------------
// write side, allocator to bank queues
// ----------------------------------------
interface alloc_if;

  logic                  wr_fire;   // request taken this cycle
  xbar_pkg::entry_id_t   wr_ptr;
  xbar_pkg::bank_id_t    wr_bank;
  xbar_pkg::ch_req_arr_t entries;   // payload storage

  modport alloc (
    output wr_fire, wr_ptr, wr_bank, entries
  );

  modport bank (
    input wr_fire, wr_ptr, wr_bank, entries
  );

  modport retire (
    input wr_fire
  );

endinterface

// ----------------------------------------
// retire side, head tracking and fill state
// ----------------------------------------
interface retire_if;

  xbar_pkg::entry_id_t   rd_ptr;        // oldest unretired entry
  logic [`CH_BANKS-1:0]  head_valid;    // one bit per bank queue
  logic                  full;
  logic                  empty;

  modport alloc  (input full, empty);
  modport bank   (input rd_ptr, output head_valid);
  modport retire (output rd_ptr, full, empty, input head_valid);

endinterface

`default_nettype wire

//--- rtl/ch_entry_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module ch_entry_alloc (
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire                req_valid_i,
  input  wire xbar_pkg::ch_req_t req_i,
  input  wire                order_fifo_allow_in_i,
  output logic               req_allow_in_o,
  output logic               order_fifo_push_o,
  alloc_if.alloc             alloc,
  retire_if.alloc            ret
);

  localparam int BANK_W = $bits(xbar_pkg::bank_id_t);

  logic                  wr_fire;
  logic                  is_ordered;
  xbar_pkg::entry_id_t   wr_ptr_q;
  xbar_pkg::entry_id_t   wr_ptr_d;
  xbar_pkg::ch_req_arr_t entries_q;

  // ----------------------------------------
  // acceptance
  // ----------------------------------------
  assign is_ordered = (req_i.op == xbar_pkg::OP_ORDERED);

  // ordered ops also need room in the keep-order fifo
  assign req_allow_in_o = ~ret.full & (~is_ordered | order_fifo_allow_in_i);

  assign wr_fire           = req_valid_i & req_allow_in_o;
  assign order_fifo_push_o = wr_fire & is_ordered;

  // ----------------------------------------
  // write pointer
  // ----------------------------------------
  assign wr_ptr_d = (wr_ptr_q == xbar_pkg::ENTRY_ID_MAX) ? '0 : wr_ptr_q + 1'b1;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (wr_fire) begin
      wr_ptr_q <= wr_ptr_d;
    end
  end

  // payload store
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      entries_q[wr_ptr_q] <= req_i;
    end
  end

  assign alloc.wr_fire = wr_fire;
  assign alloc.wr_ptr  = wr_ptr_q;
  assign alloc.wr_bank = req_i.addr[`CH_BANK_LSB +: BANK_W];  // bank select bits
  assign alloc.entries = entries_q;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // full comes from the retire unit's count
  a_no_fire_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i)
    alloc.wr_fire |-> !ret.full
  );

  // a write must be visible in the count one cycle later
  a_fire_fills: assert property (
    @(posedge clk_i) disable iff (rst_i)
    alloc.wr_fire |=> !ret.empty
  );

endmodule

`default_nettype wire

//--- rtl/ch_bank_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module ch_bank_queue #(
  parameter int unsigned BANK_ID = 0
) (
  input  wire                clk_i,
  input  wire                rst_i,
  alloc_if.bank              alloc,
  retire_if.bank             ret,
  input  wire                grant_i,
  input  wire                can_go_i,
  output logic               has_entry_o,
  output xbar_pkg::ch_req_t  req_o
);

  localparam int REQ_W = $bits(xbar_pkg::ch_req_t);

  xbar_pkg::entry_vec_t valid_q;
  xbar_pkg::entry_vec_t valid_d;
  xbar_pkg::entry_vec_t set_vec;
  xbar_pkg::entry_vec_t clr_vec;
  xbar_pkg::entry_vec_t sel_oh;    // oldest pending entry, one-hot
  xbar_pkg::entry_id_t  scan_id;
  logic                 found;
  logic                 mine;
  logic                 take;

  // ----------------------------------------
  // valid array
  // ----------------------------------------
  assign mine = alloc.wr_fire & (alloc.wr_bank == xbar_pkg::bank_id_t'(BANK_ID));

  always_comb begin
    set_vec = '0;
    if (mine) begin
      set_vec[alloc.wr_ptr] = 1'b1;
    end
  end

  assign take    = grant_i & can_go_i & has_entry_o;
  assign clr_vec = sel_oh & {`CH_ENTRIES{take}};
  assign valid_d = (valid_q & ~clr_vec) | set_vec;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // ----------------------------------------
  // oldest pick, scan from rd_ptr with wrap
  // ----------------------------------------
  always_comb begin
    sel_oh  = '0;
    found   = 1'b0;
    scan_id = ret.rd_ptr;
    for (int i = 0; i < `CH_ENTRIES; i++) begin
      if (!found && valid_q[scan_id]) begin
        sel_oh[scan_id] = 1'b1;
        found           = 1'b1;
      end
      scan_id = (scan_id == xbar_pkg::ENTRY_ID_MAX) ? '0 : scan_id + 1'b1;
    end
  end

  assign has_entry_o = found;

  // payload mux
  always_comb begin
    req_o = '0;
    for (int i = 0; i < `CH_ENTRIES; i++) begin
      req_o = req_o | ({REQ_W{sel_oh[i]}} & alloc.entries[i]);
    end
  end

  // blocks retirement while set
  assign ret.head_valid[BANK_ID] = valid_q[ret.rd_ptr];

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // a take hits one live entry and that entry is gone next cycle
  a_take_clears: assert property (
    @(posedge clk_i) disable iff (rst_i)
    take |-> $onehot(sel_oh) ##1 ((valid_q & $past(sel_oh)) == '0)
  );

  // allocator must never reuse an entry this bank still holds
  a_set_free_slot: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (set_vec != '0) |-> ((valid_q & set_vec) == '0)
  );

endmodule

`default_nettype wire

//--- rtl/ch_entry_retire.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module ch_entry_retire (
  input  wire        clk_i,
  input  wire        rst_i,
  alloc_if.retire    alloc,
  retire_if.retire   ret
);

  localparam int CNT_W = $clog2(`CH_ENTRIES + 1);

  xbar_pkg::entry_id_t rd_ptr_q;
  logic [CNT_W-1:0]    used_q;
  logic                rd_adv;

  // head taken by its bank once no queue still holds it
  assign rd_adv = (used_q != '0) & ~(|ret.head_valid);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (rd_adv) begin
      rd_ptr_q <= (rd_ptr_q == xbar_pkg::ENTRY_ID_MAX) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // used entries
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      used_q <= '0;
    end else begin
      case ({alloc.wr_fire, rd_adv})
        2'b10:   used_q <= used_q + 1'b1;
        2'b01:   used_q <= used_q - 1'b1;
        default: used_q <= used_q;  // both or neither
      endcase
    end
  end

  assign ret.rd_ptr = rd_ptr_q;
  assign ret.full   = (used_q == CNT_W'(`CH_ENTRIES));
  assign ret.empty  = (used_q == '0);

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_count_bound: assert property (
    @(posedge clk_i) disable iff (rst_i)
    used_q <= CNT_W'(`CH_ENTRIES)
  );

  // nothing stored means no bank can claim the head
  a_empty_no_head: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ret.empty |-> (ret.head_valid == '0)
  );

endmodule

`default_nettype wire

//--- rtl/ch_req_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module ch_req_buffer (
  input  wire                    clk_i,
  input  wire                    rst_i,

  // request side
  input  wire                    req_valid_i,
  input  wire xbar_pkg::op_t     req_op_i,
  input  wire xbar_pkg::addr_t   req_addr_i,
  input  wire xbar_pkg::data_t   req_data_i,
  output logic                   req_allow_in_o,

  // keep-order fifo
  output logic                   order_fifo_push_o,
  input  wire                    order_fifo_allow_in_i,

  // bank side
  output logic [`CH_BANKS-1:0]   bank_has_entry_o,
  input  wire  [`CH_BANKS-1:0]   bank_grant_i,
  input  wire  [`CH_BANKS-1:0]   bank_can_go_i,
  output xbar_pkg::op_t          bank_op_o   [`CH_BANKS],
  output xbar_pkg::addr_t        bank_addr_o [`CH_BANKS],
  output xbar_pkg::data_t        bank_data_o [`CH_BANKS]
);

  xbar_pkg::ch_req_t req;
  xbar_pkg::ch_req_t bank_req [`CH_BANKS];

  alloc_if  alloc_bus ();
  retire_if ret_bus ();

  assign req.op   = req_op_i;
  assign req.addr = req_addr_i;
  assign req.data = req_data_i;

  // ----------------------------------------
  // write side
  // ----------------------------------------
  ch_entry_alloc entry_alloc_inst (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .req_valid_i           (req_valid_i),
    .req_i                 (req),
    .order_fifo_allow_in_i (order_fifo_allow_in_i),
    .req_allow_in_o        (req_allow_in_o),
    .order_fifo_push_o     (order_fifo_push_o),
    .alloc                 (alloc_bus.alloc),
    .ret                   (ret_bus.alloc)
  );

  // ----------------------------------------
  // one queue per bank
  // ----------------------------------------
  for (genvar b = 0; b < `CH_BANKS; b++) begin : g_bank
    ch_bank_queue #(
      .BANK_ID (b)
    ) bank_queue_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .alloc       (alloc_bus.bank),
      .ret         (ret_bus.bank),
      .grant_i     (bank_grant_i[b]),
      .can_go_i    (bank_can_go_i[b]),
      .has_entry_o (bank_has_entry_o[b]),
      .req_o       (bank_req[b])
    );

    assign bank_op_o[b]   = bank_req[b].op;
    assign bank_addr_o[b] = bank_req[b].addr;
    assign bank_data_o[b] = bank_req[b].data;
  end

  // in-order free
  ch_entry_retire entry_retire_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .alloc (alloc_bus.retire),
    .ret   (ret_bus.retire)
  );

endmodule

`default_nettype wire

//--- verif/tb_ch_req_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module tb_ch_req_buffer;

  localparam int BANK_W          = $bits(xbar_pkg::bank_id_t);
  localparam int MQ_DEPTH        = 8;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 10;

  logic                  clk_i;
  logic                  rst_i;
  logic                  req_valid_i;
  xbar_pkg::op_t         req_op_i;
  xbar_pkg::addr_t       req_addr_i;
  xbar_pkg::data_t       req_data_i;
  logic                  req_allow_in_o;
  logic                  order_fifo_push_o;
  logic                  order_fifo_allow_in_i;
  logic [`CH_BANKS-1:0]  bank_has_entry_o;
  logic [`CH_BANKS-1:0]  bank_grant_i;
  logic [`CH_BANKS-1:0]  bank_can_go_i;
  xbar_pkg::op_t         bank_op_o   [`CH_BANKS];
  xbar_pkg::addr_t       bank_addr_o [`CH_BANKS];
  xbar_pkg::data_t       bank_data_o [`CH_BANKS];

  integer seed;

  // per-bank queue model
  xbar_pkg::ch_req_t model_req  [`CH_BANKS][MQ_DEPTH];
  int                model_head [`CH_BANKS];
  int                model_cnt  [`CH_BANKS];

  ch_req_buffer ch_req_buffer_inst (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .req_valid_i           (req_valid_i),
    .req_op_i              (req_op_i),
    .req_addr_i            (req_addr_i),
    .req_data_i            (req_data_i),
    .req_allow_in_o        (req_allow_in_o),
    .order_fifo_push_o     (order_fifo_push_o),
    .order_fifo_allow_in_i (order_fifo_allow_in_i),
    .bank_has_entry_o      (bank_has_entry_o),
    .bank_grant_i          (bank_grant_i),
    .bank_can_go_i         (bank_can_go_i),
    .bank_op_o             (bank_op_o),
    .bank_addr_o           (bank_addr_o),
    .bank_data_o           (bank_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired, the tests did not finish in time");
    $display("TESTS FAILED");
    $fatal(1);
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_req(input string name, input xbar_pkg::ch_req_t exp,
                           input xbar_pkg::ch_req_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bank(input string name, input xbar_pkg::bank_id_t exp,
                            input xbar_pkg::bank_id_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic tick();
    @(posedge clk_i);
    #1;  // drive point
  endtask

  function automatic xbar_pkg::ch_req_t rand_req(input xbar_pkg::op_t op,
                                                 input xbar_pkg::bank_id_t bank);
    xbar_pkg::ch_req_t r;
    r.op   = op;
    r.addr = xbar_pkg::addr_t'($random(seed));
    r.addr[`CH_BANK_LSB +: BANK_W] = bank;
    r.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
    return r;
  endfunction

  function automatic xbar_pkg::ch_req_t bank_out(input int b);
    xbar_pkg::ch_req_t r;
    r.op   = bank_op_o[b];
    r.addr = bank_addr_o[b];
    r.data = bank_data_o[b];
    return r;
  endfunction

  task automatic model_push(input xbar_pkg::ch_req_t r);
    int b;
    b = int'(r.addr[`CH_BANK_LSB +: BANK_W]);
    model_req[b][(model_head[b] + model_cnt[b]) % MQ_DEPTH] = r;
    model_cnt[b]++;
  endtask

  task automatic model_pop(input int b);
    model_head[b] = (model_head[b] + 1) % MQ_DEPTH;
    model_cnt[b]--;
  endtask

  task automatic drive_req(input xbar_pkg::ch_req_t r);
    req_valid_i = 1'b1;
    req_op_i    = r.op;
    req_addr_i  = r.addr;
    req_data_i  = r.data;
  endtask

  task automatic go_idle();
    req_valid_i = 1'b0;
    req_op_i    = 2'd1;  // non-ordered, so allow-in tracks full only
  endtask

  // hold the request until allow-in, then let it in
  task automatic send_req(input xbar_pkg::ch_req_t r);
    drive_req(r);
    @(negedge clk_i);
    while (!req_allow_in_o) begin
      check_bit("order_fifo_push_o", 1'b0, order_fifo_push_o);
      tick();
      @(negedge clk_i);
    end
    check_bit("order_fifo_push_o", r.op == xbar_pkg::OP_ORDERED, order_fifo_push_o);
    tick();
    go_idle();
    model_push(r);
  endtask

  task automatic take_bank(input int b);
    bank_grant_i[b] = 1'b1;
    @(negedge clk_i);
    check_bit($sformatf("bank_has_entry_o[%0d]", b), 1'b1, bank_has_entry_o[b]);
    check_req($sformatf("bank %0d payload", b), model_req[b][model_head[b]], bank_out(b));
    tick();
    bank_grant_i[b] = 1'b0;
    model_pop(b);
  endtask

  task automatic check_idle();
    @(negedge clk_i);
    for (int b = 0; b < `CH_BANKS; b++) begin
      check_bit($sformatf("bank_has_entry_o[%0d]", b), 1'b0, bank_has_entry_o[b]);
    end
    check_bit("req_allow_in_o", 1'b1, req_allow_in_o);
    check_bit("order_fifo_push_o", 1'b0, order_fifo_push_o);
    tick();
  endtask

  // retirement frees one entry per cycle
  task automatic settle();
    repeat (`CH_ENTRIES + 2) tick();
    check_idle();
  endtask

  task automatic drain_all();
    for (int b = 0; b < `CH_BANKS; b++) begin
      while (model_cnt[b] > 0) take_bank(b);
    end
    settle();
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_routing();
    xbar_pkg::ch_req_t  r;
    xbar_pkg::bank_id_t hit;
    for (int b = 0; b < `CH_BANKS; b++) begin
      r = rand_req(xbar_pkg::op_t'($random(seed)), xbar_pkg::bank_id_t'(b));
      send_req(r);
      @(negedge clk_i);
      hit = '0;
      for (int k = 0; k < `CH_BANKS; k++) begin
        if (bank_has_entry_o[k]) hit = xbar_pkg::bank_id_t'(k);
      end
      check_bank("routed bank", xbar_pkg::bank_id_t'(b), hit);
      for (int k = 0; k < `CH_BANKS; k++) begin
        check_bit($sformatf("bank_has_entry_o[%0d]", k), k == b, bank_has_entry_o[k]);
      end
      check_req("routed payload", r, bank_out(b));
      tick();
      take_bank(b);
      settle();
    end
  endtask

  task automatic test_bank_order();
    for (int i = 0; i < 3; i++) send_req(rand_req(2'd2, 2'd2));
    for (int i = 0; i < 3; i++) take_bank(2);  // back to back grants
    settle();
  endtask

  task automatic test_full_stall();
    xbar_pkg::ch_req_t  r;
    xbar_pkg::bank_id_t first_bank;
    for (int i = 0; i < `CH_ENTRIES; i++) begin
      r = rand_req(2'd1, xbar_pkg::bank_id_t'($random(seed)));
      if (i == 0) first_bank = r.addr[`CH_BANK_LSB +: BANK_W];
      send_req(r);
    end
    r = rand_req(2'd3, xbar_pkg::bank_id_t'($random(seed)));
    drive_req(r);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("req_allow_in_o", 1'b0, req_allow_in_o);
      tick();
    end
    take_bank(int'(first_bank));
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b0, req_allow_in_o);  // head still counted
    tick();
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b1, req_allow_in_o);
    tick();
    go_idle();
    model_push(r);
    drain_all();
  endtask

  task automatic test_keep_order();
    xbar_pkg::ch_req_t r;
    send_req(rand_req(2'd0, 2'd1));
    send_req(rand_req(2'd2, 2'd3));
    order_fifo_allow_in_i = 1'b0;
    drive_req(rand_req(2'd0, 2'd2));
    repeat (2) begin
      @(negedge clk_i);
      check_bit("req_allow_in_o", 1'b0, req_allow_in_o);
      check_bit("order_fifo_push_o", 1'b0, order_fifo_push_o);
      tick();
    end
    r = rand_req(2'd3, 2'd2);
    drive_req(r);
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b1, req_allow_in_o);
    check_bit("order_fifo_push_o", 1'b0, order_fifo_push_o);
    tick();
    go_idle();
    model_push(r);
    order_fifo_allow_in_i = 1'b1;
    drain_all();
  endtask

  task automatic test_retire_order();
    bank_can_go_i[0] = 1'b0;
    send_req(rand_req(2'd1, 2'd0));  // oldest entry, held back
    for (int i = 0; i < `CH_ENTRIES - 1; i++) send_req(rand_req(2'd2, 2'd1));
    bank_grant_i[0] = 1'b1;
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b0, req_allow_in_o);
    tick();
    bank_grant_i[0] = 1'b0;
    for (int i = 0; i < `CH_ENTRIES - 1; i++) take_bank(1);
    repeat (`CH_ENTRIES + 2) begin
      @(negedge clk_i);
      check_bit("req_allow_in_o", 1'b0, req_allow_in_o);
      check_bit("bank_has_entry_o[0]", 1'b1, bank_has_entry_o[0]);
      tick();
    end
    bank_can_go_i[0] = 1'b1;
    take_bank(0);
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b0, req_allow_in_o);
    tick();
    @(negedge clk_i);
    check_bit("req_allow_in_o", 1'b1, req_allow_in_o);
    tick();
    settle();
  endtask

  task automatic test_random_traffic();
    xbar_pkg::ch_req_t      r;
    logic                   accepted;
    logic                   exp_allow;
    logic                   adv;
    logic                   done;
    logic [`CH_BANKS-1:0]   takes;
    int                     used;
    int                     rd;
    int                     slot;
    int                     ring_bank [`CH_ENTRIES];
    logic [`CH_ENTRIES-1:0] ring_live;
    // entries in arrival order, buffer starts empty
    used      = 0;
    rd        = 0;
    ring_live = '0;
    for (int n = 0; n < 120; n++) begin
      r = rand_req(xbar_pkg::op_t'($random(seed)), xbar_pkg::bank_id_t'($random(seed)));
      drive_req(r);
      req_valid_i           = ($random(seed) & 3) != 0;
      order_fifo_allow_in_i = ($random(seed) & 3) != 0;
      bank_grant_i          = `CH_BANKS'($random(seed));
      bank_can_go_i         = ~(`CH_BANKS'($random(seed) & $random(seed)));
      @(negedge clk_i);
      for (int b = 0; b < `CH_BANKS; b++) begin
        check_bit($sformatf("bank_has_entry_o[%0d]", b), model_cnt[b] != 0,
                  bank_has_entry_o[b]);
        if (model_cnt[b] != 0) begin
          check_req($sformatf("bank %0d payload", b), model_req[b][model_head[b]],
                    bank_out(b));
        end
        takes[b] = bank_grant_i[b] & bank_can_go_i[b] & (model_cnt[b] != 0);
      end
      exp_allow = (used != `CH_ENTRIES) &&
                  (r.op != xbar_pkg::OP_ORDERED || order_fifo_allow_in_i);
      check_bit("req_allow_in_o", exp_allow, req_allow_in_o);
      accepted = req_valid_i & exp_allow;
      check_bit("order_fifo_push_o", accepted & (r.op == xbar_pkg::OP_ORDERED),
                order_fifo_push_o);
      tick();
      adv = (used != 0) && !ring_live[rd];  // head already freed before this edge
      for (int b = 0; b < `CH_BANKS; b++) begin
        if (takes[b]) begin
          model_pop(b);
          done = 1'b0;
          for (int k = 0; k < `CH_ENTRIES; k++) begin
            slot = (rd + k) % `CH_ENTRIES;
            if (!done && ring_live[slot] && ring_bank[slot] == b) begin
              ring_live[slot] = 1'b0;
              done            = 1'b1;
            end
          end
        end
      end
      if (accepted) begin
        model_push(r);
        slot            = (rd + used) % `CH_ENTRIES;
        ring_bank[slot] = int'(r.addr[`CH_BANK_LSB +: BANK_W]);
        ring_live[slot] = 1'b1;
        used++;
      end
      if (adv) begin
        rd = (rd + 1) % `CH_ENTRIES;
        used--;
      end
    end
    go_idle();
    bank_grant_i          = '0;
    bank_can_go_i         = '1;
    order_fifo_allow_in_i = 1'b1;
    drain_all();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    seed                  = 32'h07c4_bb95;
    rst_i                 = 1'b1;
    req_valid_i           = 1'b0;
    req_op_i              = 2'd1;
    req_addr_i            = '0;
    req_data_i            = '0;
    order_fifo_allow_in_i = 1'b1;
    bank_grant_i          = '0;
    bank_can_go_i         = '1;
    for (int b = 0; b < `CH_BANKS; b++) begin
      model_head[b] = 0;
      model_cnt[b]  = 0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_idle();

    test_routing();
    test_bank_order();
    test_full_stall();
    test_keep_order();
    test_retire_order();
    test_random_traffic();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/xbar_pkg.sv
rtl/xbar_if.sv
rtl/ch_entry_alloc.sv
rtl/ch_bank_queue.sv
rtl/ch_entry_retire.sv
rtl/ch_req_buffer.sv
verif/tb_ch_req_buffer.sv
